/* project.f */
stream_pkg.sv
stream_fifo_mem.sv
stream_fifo.sv
lane_spreader.sv
lane_gatherer.sv
stream_lanes_top.sv
tb_stream_lanes.sv

/* Bender.yml */
package:
  name: stream_lanes

sources:
  - stream_pkg.sv
  - stream_fifo_mem.sv
  - stream_fifo.sv
  - lane_spreader.sv
  - lane_gatherer.sv
  - stream_lanes_top.sv
  - target: simulation
    files:
      - tb_stream_lanes.sv

/* tb_stream_lanes.sv */
`timescale 1ns/1ns

module tb_stream_lanes;

  //////////////////////////////////////////////////
  // test sizes and run limit
  //////////////////////////////////////////////////

  localparam int N_STREAM     = 64;
  localparam int N_RANDOM     = 200;
  localparam int N_FILL       = stream_pkg::LANES * stream_pkg::DEPTH;
  localparam int N_LAST       = 70;
  localparam int N_PRE_RESET  = 20;
  localparam int N_POST_RESET = 16;
  localparam int TOTAL_BEATS  = N_STREAM + N_RANDOM + N_FILL + N_LAST + N_PRE_RESET
                                + N_POST_RESET;
  localparam int TIMEOUT_CYCLES = TOTAL_BEATS * 8 + 200;

  logic              clk_i;
  logic              rst_i;
  logic              in_valid_i;
  stream_pkg::beat_t in_beat_i;
  logic              in_ready_o;
  logic              out_valid_o;
  stream_pkg::beat_t out_beat_o;
  logic              out_ready_i;

  // beats accepted at the input and not yet seen at the output.
  stream_pkg::beat_t exp_q[$];
  stream_pkg::beat_t exp_beat;

  logic [31:0] lfsr_q;
  int          ready_mode;
  string       cur_test;
  int          err_cnt;
  int          err_mark;
  int          tests_ok;
  int          tests_bad;
  int          last_cnt;
  int          cycle_cnt;

  stream_lanes_top stream_lanes_top_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_beat_i   (in_beat_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_beat_o  (out_beat_o),
    .out_ready_i (out_ready_i)
  );

  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // random numbers and reference model
  //////////////////////////////////////////////////

  // galois form of the polynomial x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s   = s >> 1;
    if (lsb) begin
      s = s ^ 32'h8020_0003;
    end
    return s;
  endfunction

  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_step(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic stream_pkg::beat_t make_beat(int idx, bit last7);
    stream_pkg::beat_t b;
    logic [31:0]       flag;
    b.data = lfsr_bits(32);
    if (last7) begin
      b.last = (idx % 7) == 6;
    end else begin
      flag   = lfsr_bits(1);
      b.last = flag[0];
    end
    return b;
  endfunction

  // order is kept end to end, so the next output is the oldest input.
  function automatic stream_pkg::beat_t expected_beat();
    return exp_q[0];
  endfunction

  //////////////////////////////////////////////////
  // output compare and run limit
  //////////////////////////////////////////////////

  // valid and ready seen at the falling edge are what the next
  // rising edge transfers.
  always @(negedge clk_i) begin
    if (!rst_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("%s: output gave a beat that was never sent", cur_test);
        err_cnt++;
      end else begin
        exp_beat = expected_beat();
        void'(exp_q.pop_front());
        if (out_beat_o !== exp_beat) begin
          $display("FAIL %s expected %h/%0b actual %h/%0b", cur_test,
                   exp_beat.data, exp_beat.last, out_beat_o.data, out_beat_o.last);
          err_cnt++;
        end
        if (out_beat_o.last) begin
          last_cnt++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout in %s after %0d cycles", cur_test, cycle_cnt);
      $display("sim failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////

  // every input change happens 2 ns after the rising edge.
  task automatic step_cycle();
    logic [31:0] r;
    @(posedge clk_i);
    #2;
    if (ready_mode == 0) begin
      out_ready_i = 1'b1;
    end else if (ready_mode == 1) begin
      r           = lfsr_bits(2);
      out_ready_i = r != 0;
    end else begin
      out_ready_i = 1'b0;
    end
  endtask

  task automatic send_beats(int n, bit gaps, bit last7);
    int          sent;
    bit          holding;
    logic [31:0] r;
    sent    = 0;
    holding = 1'b0;
    while (sent < n) begin
      step_cycle();
      if (!holding) begin
        r = gaps ? lfsr_bits(2) : 32'd1;
        if (r == 0) begin
          in_valid_i = 1'b0;
        end else begin
          in_valid_i = 1'b1;
          in_beat_i  = make_beat(sent, last7);
          holding    = 1'b1;
        end
      end
      @(negedge clk_i);
      if (in_valid_i && in_ready_o && !rst_i) begin
        exp_q.push_back(in_beat_i);
        sent++;
        holding = 1'b0;
      end
    end
    step_cycle();
    in_valid_i = 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      step_cycle();
    end
    step_cycle();
    @(negedge clk_i);
    if (out_valid_o !== 1'b0) begin
      $display("FAIL %s out_valid_o after drain expected 0 actual %b", cur_test, out_valid_o);
      err_cnt++;
    end
  endtask

  task automatic check_idle();
    @(negedge clk_i);
    if (out_valid_o !== 1'b0) begin
      $display("FAIL %s out_valid_o expected 0 actual %b", cur_test, out_valid_o);
      err_cnt++;
    end
    if (in_ready_o !== 1'b1) begin
      $display("FAIL %s in_ready_o expected 1 actual %b", cur_test, in_ready_o);
      err_cnt++;
    end
  endtask

  task automatic start_test(string name);
    cur_test = name;
    err_mark = err_cnt;
    last_cnt = 0;
  endtask

  task automatic end_test();
    if (err_cnt == err_mark) begin
      tests_ok++;
      $display("test %s: ok", cur_test);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", cur_test, err_cnt - err_mark);
    end
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int accepted;
    int idle;
    bit holding;
    clk_i       = 1'b0;
    rst_i       = 1'b1;
    in_valid_i  = 1'b0;
    in_beat_i   = '0;
    out_ready_i = 1'b0;
    lfsr_q      = 32'hd3c7_f26f;
    ready_mode  = 0;
    err_cnt     = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    cycle_cnt   = 0;

    start_test("reset");
    repeat (10) step_cycle();
    rst_i = 1'b0;
    check_idle();
    end_test();

    start_test("streaming");
    send_beats(N_STREAM, 1'b0, 1'b0);
    drain();
    end_test();

    start_test("random_gaps");
    ready_mode = 1;
    send_beats(N_RANDOM, 1'b1, 1'b0);
    ready_mode = 0;
    drain();
    end_test();

    // with the output stalled, only LANES x DEPTH beats fit.
    start_test("fill");
    ready_mode = 2;
    accepted   = 0;
    idle       = 0;
    holding    = 1'b0;
    while (idle < 16) begin
      step_cycle();
      if (!holding) begin
        in_beat_i = make_beat(accepted, 1'b0);
        holding   = 1'b1;
      end
      in_valid_i = 1'b1;
      @(negedge clk_i);
      if (in_ready_o) begin
        exp_q.push_back(in_beat_i);
        accepted++;
        holding = 1'b0;
        idle    = 0;
      end else begin
        idle++;
      end
    end
    step_cycle();
    in_valid_i = 1'b0;
    if (accepted != N_FILL) begin
      $display("FAIL %s accepted beats expected %0d actual %0d", cur_test, N_FILL, accepted);
      err_cnt++;
    end
    ready_mode = 0;
    drain();
    end_test();

    start_test("last_flag");
    ready_mode = 1;
    send_beats(N_LAST, 1'b1, 1'b1);
    ready_mode = 0;
    drain();
    if (last_cnt != N_LAST / 7) begin
      $display("FAIL %s last flags expected %0d actual %0d", cur_test, N_LAST / 7, last_cnt);
      err_cnt++;
    end
    end_test();

    // beats still in the lanes are dropped by the reset.
    start_test("mid_reset");
    ready_mode = 1;
    send_beats(N_PRE_RESET, 1'b1, 1'b0);
    step_cycle();
    rst_i = 1'b1;
    exp_q.delete();
    repeat (10) step_cycle();
    rst_i      = 1'b0;
    ready_mode = 0;
    check_idle();
    send_beats(N_POST_RESET, 1'b0, 1'b0);
    drain();
    end_test();

    $display("tests: %0d ok, %0d with errors, %0d errors", tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* stream_lanes_top.sv */
`timescale 1ns/1ns

module stream_lanes_top (
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              in_valid_i,
  input  stream_pkg::beat_t in_beat_i,
  output logic              in_ready_o,

  output logic              out_valid_o,
  output stream_pkg::beat_t out_beat_o,
  input  logic              out_ready_i
);

  // spreader side of the lanes.
  logic [stream_pkg::LANES-1:0] spr_valid;
  stream_pkg::beat_t            spr_beat;
  logic [stream_pkg::LANES-1:0] spr_ready;

  // gatherer side of the lanes.
  logic [stream_pkg::LANES-1:0] gat_valid;
  stream_pkg::beat_t            gat_beat [stream_pkg::LANES];
  logic [stream_pkg::LANES-1:0] gat_ready;

  //////////////////////////////////////////////////
  // input side
  //////////////////////////////////////////////////

  lane_spreader lane_spreader_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_valid_i   (in_valid_i),
    .in_beat_i    (in_beat_i),
    .in_ready_o   (in_ready_o),
    .lane_valid_o (spr_valid),
    .lane_beat_o  (spr_beat),
    .lane_ready_i (spr_ready)
  );

  //////////////////////////////////////////////////
  // lane FIFOs
  //////////////////////////////////////////////////

  for (genvar l = 0; l < stream_pkg::LANES; l++) begin : g_lane
    stream_fifo lane_fifo_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .in_valid_i  (spr_valid[l]),
      .in_beat_i   (spr_beat),
      .in_ready_o  (spr_ready[l]),
      .out_valid_o (gat_valid[l]),
      .out_beat_o  (gat_beat[l]),
      .out_ready_i (gat_ready[l])
    );
  end

  //////////////////////////////////////////////////
  // output side
  //////////////////////////////////////////////////

  lane_gatherer lane_gatherer_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .lane_valid_i (gat_valid),
    .lane_beat_i  (gat_beat),
    .lane_ready_o (gat_ready),
    .out_valid_o  (out_valid_o),
    .out_beat_o   (out_beat_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

/* lane_gatherer.sv */
`timescale 1ns/1ns

module lane_gatherer (
  input  logic                         clk_i,
  input  logic                         rst_i,

  input  logic [stream_pkg::LANES-1:0] lane_valid_i,
  input  stream_pkg::beat_t            lane_beat_i [stream_pkg::LANES],
  output logic [stream_pkg::LANES-1:0] lane_ready_o,

  output logic                         out_valid_o,
  output stream_pkg::beat_t            out_beat_o,
  input  logic                         out_ready_i
);

  // lane that supplies the next output beat.
  stream_pkg::lane_idx_t rd_lane_q;

  logic fire;

  //////////////////////////////////////////////////
  // selection
  //////////////////////////////////////////////////

  // the output waits on the selected lane even if others hold data.
  // that keeps the beats in input order.
  assign out_valid_o = lane_valid_i[rd_lane_q];
  assign out_beat_o  = lane_beat_i[rd_lane_q];

  always_comb begin
    lane_ready_o            = '0;
    lane_ready_o[rd_lane_q] = out_ready_i;
  end

  assign fire = out_valid_o && out_ready_i;

  //////////////////////////////////////////////////
  // round-robin pointer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_lane_q <= '0;
    end else if (fire) begin
      if (rd_lane_q == stream_pkg::lane_idx_t'(stream_pkg::LANES - 1)) begin
        rd_lane_q <= '0;
      end else begin
        rd_lane_q <= rd_lane_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // an offered beat stays on the output until it is taken, so neither
  // the pointer nor the selected lane may move it away while stalled.
  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_beat_o)))
    else $error("output beat changed while stalled");

endmodule

/* lane_spreader.sv */
`timescale 1ns/1ns

module lane_spreader (
  input  logic                         clk_i,
  input  logic                         rst_i,

  input  logic                         in_valid_i,
  input  stream_pkg::beat_t            in_beat_i,
  output logic                         in_ready_o,

  output logic [stream_pkg::LANES-1:0] lane_valid_o,
  output stream_pkg::beat_t            lane_beat_o,
  input  logic [stream_pkg::LANES-1:0] lane_ready_i
);

  // lane that takes the next input beat.
  stream_pkg::lane_idx_t wr_lane_q;

  logic fire;

  //////////////////////////////////////////////////
  // routing
  //////////////////////////////////////////////////

  // the beat goes to every lane, but only the selected lane sees valid.
  assign lane_beat_o = in_beat_i;

  always_comb begin
    lane_valid_o            = '0;
    lane_valid_o[wr_lane_q] = in_valid_i;
  end

  // the input stalls exactly when the selected lane is full.
  assign in_ready_o = lane_ready_i[wr_lane_q];

  assign fire = in_valid_i && in_ready_o;

  //////////////////////////////////////////////////
  // round-robin pointer
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_lane_q <= '0;
    end else if (fire) begin
      if (wr_lane_q == stream_pkg::lane_idx_t'(stream_pkg::LANES - 1)) begin
        wr_lane_q <= '0;
      end else begin
        wr_lane_q <= wr_lane_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // a lane runs full only by taking a beat from the spreader, so a
  // drop in its ready without a transfer there means lost order.
  for (genvar l = 0; l < stream_pkg::LANES; l++) begin : g_ready_chk
    assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(lane_ready_i[l]) |-> $past(lane_valid_o[l] && lane_ready_i[l]))
      else $error("lane stopped taking beats without a transfer");
  end

endmodule

/* stream_fifo.sv */
`timescale 1ns/1ns

module stream_fifo (
  input  logic              clk_i,
  input  logic              rst_i,

  input  logic              in_valid_i,
  input  stream_pkg::beat_t in_beat_i,
  output logic              in_ready_o,

  output logic              out_valid_o,
  output stream_pkg::beat_t out_beat_o,
  input  logic              out_ready_i
);

  logic [stream_pkg::ADDR_W-1:0]      w_ptr_q;
  logic [stream_pkg::ADDR_W-1:0]      r_ptr_q;
  stream_pkg::cnt_t                   cnt_q;
  logic [stream_pkg::PIPE_STAGES-1:0] valid_q;

  stream_pkg::cnt_t                   pipe_cnt;
  stream_pkg::cnt_t                   mem_cnt;
  logic [stream_pkg::PIPE_STAGES-1:0] shift;
  logic                               push;
  logic                               pop;
  logic                               r_en;

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // occupancy counts words in memory and in the pipeline together.
  assign in_ready_o  = cnt_q < stream_pkg::cnt_t'(stream_pkg::DEPTH);
  assign out_valid_o = valid_q[stream_pkg::PIPE_STAGES-1];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  //////////////////////////////////////////////////
  // pipeline control
  //////////////////////////////////////////////////

  // a stage may advance when the output is taken or when any stage at
  // or after it is empty. walking from the output backwards keeps a
  // running flag of bubbles seen so far.
  always_comb begin
    logic bubble_seen;
    bubble_seen = 1'b0;
    for (int j = stream_pkg::PIPE_STAGES - 1; j >= 0; j--) begin
      bubble_seen = bubble_seen | ~valid_q[j];
      shift[j]    = out_ready_i | bubble_seen;
    end
  end

  // words still in memory are the occupancy minus the full stages.
  always_comb begin
    pipe_cnt = '0;
    for (int j = 0; j < stream_pkg::PIPE_STAGES; j++) begin
      pipe_cnt = pipe_cnt + stream_pkg::cnt_t'(valid_q[j]);
    end
    mem_cnt = cnt_q - pipe_cnt;
  end

  // read as soon as stage 0 can take the word.
  assign r_en = (mem_cnt != '0) && shift[0];

  //////////////////////////////////////////////////
  // state
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      w_ptr_q <= '0;
      r_ptr_q <= '0;
      cnt_q   <= '0;
      valid_q <= '0;
    end else begin
      if (push) begin
        w_ptr_q <= w_ptr_q + 1'b1;
      end
      if (r_en) begin
        r_ptr_q <= r_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + stream_pkg::cnt_t'(push) - stream_pkg::cnt_t'(pop);
      for (int j = stream_pkg::PIPE_STAGES - 1; j > 0; j--) begin
        if (shift[j]) begin
          valid_q[j] <= valid_q[j-1];
        end
      end
      if (shift[0]) begin
        valid_q[0] <= r_en;
      end
    end
  end

  stream_fifo_mem fifo_mem_i (
    .clk_i    (clk_i),
    .w_en_i   (push),
    .w_addr_i (w_ptr_q),
    .w_beat_i (in_beat_i),
    .r_en_i   (r_en),
    .r_addr_i (r_ptr_q),
    .shift_i  (shift),
    .r_beat_o (out_beat_o)
  );

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  // the memory must never be written over a word it still holds.
  // equal pointers mean an empty or a full memory, and only empty is safe.
  assert property (@(posedge clk_i) disable iff (rst_i)
    push |-> ((w_ptr_q != r_ptr_q) || (mem_cnt == '0)))
    else $error("write into a full lane");

  // a stalled output word must hold in the memory pipeline.
  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_beat_o)))
    else $error("lane output changed while stalled");

  assert property (@(posedge clk_i) disable iff (rst_i)
    cnt_q <= stream_pkg::cnt_t'(stream_pkg::DEPTH))
    else $error("lane occupancy above depth");

endmodule

/* stream_fifo_mem.sv */
`timescale 1ns/1ns

module stream_fifo_mem (
  input  logic                          clk_i,

  input  logic                          w_en_i,
  input  logic [stream_pkg::ADDR_W-1:0] w_addr_i,
  input  stream_pkg::beat_t             w_beat_i,

  input  logic                          r_en_i,
  input  logic [stream_pkg::ADDR_W-1:0] r_addr_i,

  input  logic [stream_pkg::PIPE_STAGES-1:0] shift_i,
  output stream_pkg::beat_t             r_beat_o
);

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // words wait here between their write and their read.
  stream_pkg::beat_t mem_q [stream_pkg::DEPTH];

  // output pipeline; stage 0 is fed by the read port and the
  // last stage drives the lane output.
  stream_pkg::beat_t pipe_q [stream_pkg::PIPE_STAGES];

  //////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (w_en_i) begin
      mem_q[w_addr_i] <= w_beat_i;
    end
  end

  //////////////////////////////////////////////////
  // read port and output pipeline
  //////////////////////////////////////////////////

  // a read lands in stage 0 when that stage is free to take it.
  always_ff @(posedge clk_i) begin
    if (r_en_i && shift_i[0]) begin
      pipe_q[0] <= mem_q[r_addr_i];
    end
  end

  // later stages copy their predecessor when their shift bit is set.
  // a stage shifts when the output is taken or a bubble sits at or
  // after it, so words close up behind a stalled output.
  always_ff @(posedge clk_i) begin
    for (int j = stream_pkg::PIPE_STAGES - 1; j > 0; j--) begin
      if (shift_i[j]) begin
        pipe_q[j] <= pipe_q[j-1];
      end
    end
  end

  // only the last stage is visible outside.
  assign r_beat_o = pipe_q[stream_pkg::PIPE_STAGES-1];

endmodule

/* stream_pkg.sv */
package stream_pkg;

  //////////////////////////////////////////////////
  // stream geometry
  //////////////////////////////////////////////////

  // width of one data word.
  localparam int DATA_W = 32;

  // number of lane FIFOs behind the spreader.
  localparam int LANES = 4;

  // beats one lane can hold, output pipeline included.
  localparam int DEPTH = 8;

  // output registers behind the memory read port.
  localparam int PIPE_STAGES = 2;

  // address and counter widths follow from the depth.
  localparam int ADDR_W = $clog2(DEPTH);
  localparam int CNT_W  = ADDR_W + 1;

  // width of a lane number.
  localparam int LANE_W = $clog2(LANES);

  //////////////////////////////////////////////////
  // shared types
  //////////////////////////////////////////////////

  // one beat of the stream.
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } beat_t;

  // round-robin lane pointer.
  typedef logic [LANE_W-1:0] lane_idx_t;

  // occupancy count, wide enough to hold DEPTH itself.
  typedef logic [CNT_W-1:0] cnt_t;

endpackage
